//--- icachePkg.sv
// Instruction cache geometry constants
// Miss controller state encoding
`default_nettype none

package icachePkg;

    // Line layout
    localparam int blockWords = 4;
    localparam int offsetBits = 2;

    // Set layout, index sits at addr[6:4]
    localparam int numSets = 8;
    localparam int setBits = 3;

    // Physical tag covers the word address above set and offset
    localparam int tagBits = 30 - offsetBits - setBits;

    // Associativity
    localparam int numWays = 2;

    // Miss handling states
    typedef enum logic [1:0] {
        stIdle,
        stRefill,
        stFillDone
    } ctrlState_t;

endpackage

`default_nettype wire

//--- icacheArray.sv
// Tag, valid and data storage for both cache ways
// Per-set LRU bit, combinational read at the current set
`timescale 1ns/1ps
`default_nettype none

module icacheArray import icachePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  invalidate,
    input  logic [setBits-1:0]    setIdx,
    input  logic [offsetBits-1:0] wordIdx,
    input  logic [offsetBits-1:0] fillOffset,
    input  logic                  w1We,
    input  logic                  w2We,
    input  logic                  validIn,
    input  logic [tagBits-1:0]    tagIn,
    input  logic [31:0]           fillData,
    input  logic                  lruTouch,
    input  logic                  lruWay,
    input  logic                  fillDone,
    output logic                  w1Valid,
    output logic                  w2Valid,
    output logic [tagBits-1:0]    w1Tag,
    output logic [tagBits-1:0]    w2Tag,
    output logic [31:0]           w1Word,
    output logic [31:0]           w2Word,
    output logic                  currLru
);

    // Way 1 is index 0, way 2 is index 1
    logic [31:0]        dataMem [numWays][numSets][blockWords];
    logic [tagBits-1:0] tagMem [numWays][numSets];
    logic [numSets-1:0] validBits [numWays];

    // LRU bit low means way 1 is the next victim
    logic [numSets-1:0] lruBits;

    logic [numWays-1:0] wayWe;

    assign wayWe = {w2We, w1We};

    // Refill beats land in the victim way, tag rewritten each beat
    always_ff @(posedge clk) begin
        for (int w = 0; w < numWays; w++) begin
            if (wayWe[w]) begin
                dataMem[w][setIdx][fillOffset] <= fillData;
                tagMem[w][setIdx] <= tagIn;
            end
        end
    end

    // Line state
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int w = 0; w < numWays; w++) begin
                validBits[w] <= '0;
            end
            lruBits <= '0;
        end else begin
            if (invalidate) begin
                for (int w = 0; w < numWays; w++) begin
                    validBits[w] <= '0;
                end
            end else if (fillDone) begin
                validBits[lruWay][setIdx] <= validIn;
            end

            // Point away from the way just used
            if (lruTouch || fillDone) begin
                lruBits[setIdx] <= ~lruWay;
            end
        end
    end

    // Lookup read port
    assign w1Valid = validBits[0][setIdx];
    assign w2Valid = validBits[1][setIdx];
    assign w1Tag   = tagMem[0][setIdx];
    assign w2Tag   = tagMem[1][setIdx];
    assign w1Word  = dataMem[0][setIdx][wordIdx];
    assign w2Word  = dataMem[1][setIdx][wordIdx];
    assign currLru = lruBits[setIdx];

    // A refill targets a single way
    assert property (@(posedge clk) disable iff (!rstN)
        $countones(wayWe) < numWays)
        else $error("both way write enables high");

endmodule

`default_nettype wire

//--- icacheHitCompare.sv
// Tag compare across both ways
// Hit detect, hit way and read word select
`timescale 1ns/1ps
`default_nettype none

module icacheHitCompare import icachePkg::*; (
    input  logic [tagBits-1:0] physTag,
    input  logic               w1Valid,
    input  logic               w2Valid,
    input  logic [tagBits-1:0] w1Tag,
    input  logic [tagBits-1:0] w2Tag,
    input  logic [31:0]        w1Word,
    input  logic [31:0]        w2Word,
    output logic               hit,
    output logic               hitWay,
    output logic [31:0]        rd
);

    logic w1Match;
    logic w2Match;

    // Only a valid line can match
    assign w1Match = w1Valid && (w1Tag == physTag);
    assign w2Match = w2Valid && (w2Tag == physTag);

    assign hit = w1Match || w2Match;

    // High selects way 2
    assign hitWay = w2Match;

    // Word from the matching way, way 1 otherwise
    assign rd = w2Match ? w2Word : w1Word;

    // Victim choice must never leave one tag resident in both ways
    always_comb begin
        assert final (!(w1Match && w2Match))
            else $error("tag resident in both ways");
    end

endmodule

`default_nettype wire

//--- icacheController.sv
// Miss handling FSM with refill beat counter
// Victim way choice, way write enables, stall and bus request
`timescale 1ns/1ps
`default_nettype none

module icacheController import icachePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  enable,
    input  logic                  paReady,
    input  logic                  hit,
    input  logic                  hitWay,
    input  logic                  w1Valid,
    input  logic                  w2Valid,
    input  logic                  currLru,
    input  logic                  busReady,
    output logic                  w1We,
    output logic                  w2We,
    output logic [offsetBits-1:0] fillOffset,
    output logic                  fillDone,
    output logic                  lruTouch,
    output logic                  lruWay,
    output logic                  validIn,
    output logic                  iStall,
    output logic                  hRequest
);

    ctrlState_t state;
    ctrlState_t nextState;

    logic lookup;
    logic miss;
    logic beat;
    logic lastBeat;
    logic victimWay;
    logic victimNext;

    // Lookup only when idle with a valid translation
    assign lookup   = (state == stIdle) && paReady;
    assign miss     = lookup && !hit;
    assign lruTouch = lookup && hit;

    assign hRequest = (state == stRefill);
    assign fillDone = (state == stFillDone);

    // One word per busReady strobe
    assign beat     = hRequest && busReady;
    assign lastBeat = beat && (fillOffset == offsetBits'(blockWords - 1));

    // Stall on miss, refill, or missing translation
    assign iStall = (state != stIdle) || !paReady || !hit;

    assign w1We = beat && !victimWay;
    assign w2We = beat && victimWay;

    // Lines filled while disabled stay invalid
    assign validIn = enable;

    // Way to mark most recent
    assign lruWay = fillDone ? victimWay : hitWay;

    // Prefer an empty way, then the least recently used one
    assign victimNext = !w1Valid ? 1'b0 : (!w2Valid ? 1'b1 : currLru);

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (miss) begin
                    nextState = stRefill;
                end
            end
            stRefill: begin
                if (lastBeat) begin
                    nextState = stFillDone;
                end
            end
            stFillDone: begin
                nextState = stIdle;
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    // Wraps back to zero after the last beat
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fillOffset <= '0;
        end else if (beat) begin
            fillOffset <= fillOffset + offsetBits'(1);
        end
    end

    // Held for the whole refill
    always_ff @(posedge clk) begin
        if (miss) begin
            victimWay <= victimNext;
        end
    end

    // Request drops once the fourth word is in
    assert property (@(posedge clk) disable iff (!rstN)
        lastBeat |=> !hRequest)
        else $error("bus request held past the last beat");

    // Every refill starts at word 0 of the block
    assert property (@(posedge clk) disable iff (!rstN)
        miss |=> (state == stRefill) && (fillOffset == '0))
        else $error("refill started at nonzero offset");

endmodule

`default_nettype wire

//--- icache.sv
// Instruction cache top level
// Address field split, bus address, controller and datapath wiring
`timescale 1ns/1ps
`default_nettype none

module icache import icachePkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               enable,
    input  logic               invalidate,
    input  logic               paReady,
    input  logic [31:0]        addr,
    input  logic [tagBits-1:0] physTag,
    input  logic               busReady,
    input  logic [31:0]        hRData,
    output logic [31:0]        rd,
    output logic               iStall,
    output logic               hRequest,
    output logic [31:0]        hAddr
);

    logic [setBits-1:0]    setIdx;
    logic [offsetBits-1:0] wordIdx;
    logic [offsetBits-1:0] fillOffset;
    logic [tagBits-1:0]    w1Tag;
    logic [tagBits-1:0]    w2Tag;
    logic [31:0]           w1Word;
    logic [31:0]           w2Word;
    logic w1Valid;
    logic w2Valid;
    logic currLru;
    logic hit;
    logic hitWay;
    logic w1We;
    logic w2We;
    logic fillDone;
    logic lruTouch;
    logic lruWay;
    logic validIn;

    // Word offset above the byte bits, set index above that
    assign wordIdx = addr[offsetBits+1:2];
    assign setIdx  = addr[setBits+offsetBits+1:offsetBits+2];

    // Refill word address from the physical tag and beat counter
    assign hAddr = {physTag, setIdx, fillOffset, 2'b00};

    icacheArray u_array (
        .clk        (clk),
        .rstN       (rstN),
        .invalidate (invalidate),
        .setIdx     (setIdx),
        .wordIdx    (wordIdx),
        .fillOffset (fillOffset),
        .w1We       (w1We),
        .w2We       (w2We),
        .validIn    (validIn),
        .tagIn      (physTag),
        .fillData   (hRData),
        .lruTouch   (lruTouch),
        .lruWay     (lruWay),
        .fillDone   (fillDone),
        .w1Valid    (w1Valid),
        .w2Valid    (w2Valid),
        .w1Tag      (w1Tag),
        .w2Tag      (w2Tag),
        .w1Word     (w1Word),
        .w2Word     (w2Word),
        .currLru    (currLru)
    );

    icacheHitCompare u_hitCompare (
        .physTag (physTag),
        .w1Valid (w1Valid),
        .w2Valid (w2Valid),
        .w1Tag   (w1Tag),
        .w2Tag   (w2Tag),
        .w1Word  (w1Word),
        .w2Word  (w2Word),
        .hit     (hit),
        .hitWay  (hitWay),
        .rd      (rd)
    );

    icacheController u_controller (
        .clk        (clk),
        .rstN       (rstN),
        .enable     (enable),
        .paReady    (paReady),
        .hit        (hit),
        .hitWay     (hitWay),
        .w1Valid    (w1Valid),
        .w2Valid    (w2Valid),
        .currLru    (currLru),
        .busReady   (busReady),
        .w1We       (w1We),
        .w2We       (w2We),
        .fillOffset (fillOffset),
        .fillDone   (fillDone),
        .lruTouch   (lruTouch),
        .lruWay     (lruWay),
        .validIn    (validIn),
        .iStall     (iStall),
        .hRequest   (hRequest)
    );

endmodule

`default_nettype wire

//--- icacheTbMem.sv
// Behavioral bus memory for the cache testbench
// Random ready delay per beat, data derived from the word address
`timescale 1ns/1ps
`default_nettype none

module icacheTbMem (
    input  logic        clk,
    input  logic        rstN,
    input  logic        hRequest,
    input  logic [31:0] hAddr,
    output logic        busReady,
    output logic [31:0] hRData
);

    integer seed;
    int     waitCnt;
    logic   armed;

    // Each word is its own address with a fixed pattern folded in
    assign hRData = hAddr ^ 32'h5A5A0000;

    initial begin
        seed     = 6;
        busReady = 1'b0;
        armed    = 1'b0;
        waitCnt  = 0;
        forever begin
            @(negedge clk);
            if (!rstN || !hRequest || busReady) begin
                // Strobe lasts one cycle, the next beat draws a new delay
                busReady = 1'b0;
                armed    = 1'b0;
            end else begin
                if (!armed) begin
                    waitCnt = $unsigned($random(seed)) % 4;
                    armed   = 1'b1;
                end
                if (waitCnt == 0) begin
                    busReady = 1'b1;
                end else begin
                    waitCnt = waitCnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- icacheTb.sv
// Directed testbench for the instruction cache
// Clock, reset, bus beat monitor, test tasks and final report
`timescale 1ns/1ps
`default_nettype none

module icacheTb import icachePkg::*; ();

    logic               clk;
    logic               rstN;
    logic               enable;
    logic               invalidate;
    logic               paReady;
    logic [31:0]        addr;
    logic [tagBits-1:0] physTag;
    logic               busReady;
    logic [31:0]        hRData;
    logic [31:0]        rd;
    logic               iStall;
    logic               hRequest;
    logic [31:0]        hAddr;

    int          errors;
    int          checks;
    logic [31:0] beatAddrs[$];

    icache u_icache (
        .clk        (clk),
        .rstN       (rstN),
        .enable     (enable),
        .invalidate (invalidate),
        .paReady    (paReady),
        .addr       (addr),
        .physTag    (physTag),
        .busReady   (busReady),
        .hRData     (hRData),
        .rd         (rd),
        .iStall     (iStall),
        .hRequest   (hRequest),
        .hAddr      (hAddr)
    );

    icacheTbMem u_mem (
        .clk      (clk),
        .rstN     (rstN),
        .hRequest (hRequest),
        .hAddr    (hAddr),
        .busReady (busReady),
        .hRData   (hRData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Record the address of every completed bus beat
    always @(posedge clk) begin
        if (rstN && hRequest && busReady) begin
            beatAddrs.push_back(hAddr);
        end
    end

    // Tag on top of the untranslated set and word bits
    function automatic logic [31:0] physAddr(input logic [tagBits-1:0] tag,
                                             input logic [31:0] a);
        return {tag, a[6:2], 2'b00};
    endfunction

    function automatic logic [31:0] memWord(input logic [31:0] pa);
        return pa ^ 32'h5A5A0000;
    endfunction

    task automatic checkValue(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Fail %s %s expected %h actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    // Four beats walking the block from word 0
    task automatic checkBeats(input string name, input logic [tagBits-1:0] tag,
                              input logic [31:0] a);
        logic [31:0] expAddr;
        checkValue(name, "beat count", 32'd4, 32'(beatAddrs.size()));
        for (int k = 0; k < beatAddrs.size(); k++) begin
            expAddr = {tag, a[6:4], k[1:0], 2'b00};
            checkValue(name, "beat address", expAddr, beatAddrs[k]);
        end
    endtask

    task automatic waitStallLow(input string name, output bit ok);
        int         cycles;
        ctrlState_t st;
        cycles = 0;
        while (iStall && cycles < 100) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        ok = !iStall;
        if (!ok) begin
            st = u_icache.u_controller.state;
            $display("Timeout in %s, stall still high after 100 cycles, controller in %s",
                     name, st.name());
            errors++;
        end
    endtask

    task automatic fetch(input string name, input logic [tagBits-1:0] tag,
                         input logic [31:0] a, input bit expectMiss);
        bit missed;
        bit ok;
        @(negedge clk);
        paReady = 1'b1;
        physTag = tag;
        addr    = a;
        beatAddrs.delete();
        #1;
        missed = iStall;
        checkValue(name, "miss", 32'(expectMiss), 32'(missed));
        waitStallLow(name, ok);
        if (ok) begin
            checkValue(name, "rd", memWord(physAddr(tag, a)), rd);
            if (expectMiss) begin
                checkBeats(name, tag, a);
            end else begin
                // A hit must not start a bus request at the next edge
                @(negedge clk);
                #1;
                checkValue(name, "hRequest", 32'd0, 32'(hRequest));
                checkValue(name, "beat count", 32'd0, 32'(beatAddrs.size()));
            end
        end
    endtask

    // Refill with the line left invalid, so the stall never drops
    task automatic fetchUncached(input string name, input logic [tagBits-1:0] tag,
                                 input logic [31:0] a);
        int cycles;
        @(negedge clk);
        paReady = 1'b1;
        physTag = tag;
        addr    = a;
        beatAddrs.delete();
        cycles  = 0;
        #1;
        while (beatAddrs.size() < 4 && cycles < 100) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (beatAddrs.size() < 4) begin
            $display("Timeout in %s, refill did not finish within 100 cycles", name);
            errors++;
        end else begin
            checkBeats(name, tag, a);
            checkValue(name, "stall", 32'd1, 32'(iStall));
            // Nothing hits, so rd shows the freshly filled way 1 word
            checkValue(name, "rd", memWord(physAddr(tag, a)), rd);
        end
        @(negedge clk);
        paReady = 1'b0;
    endtask

    task automatic testReset();
        @(negedge clk);
        #1;
        checkValue("testReset", "hRequest", 32'd0, 32'(hRequest));
        checkValue("testReset", "stall without translation", 32'd1, 32'(iStall));
        fetch("testReset", 25'h00ABCDE, 32'h0000_0004, 1'b1);
    endtask

    task automatic testColdMiss();
        fetch("testColdMiss", 25'h1234567, 32'h0000_0018, 1'b1);
    endtask

    task automatic testHit();
        fetch("testHit", 25'h1234567, 32'h0000_0010, 1'b0);
        fetch("testHit", 25'h1234567, 32'h8000_0014, 1'b0);
        fetch("testHit", 25'h1234567, 32'h0000_001C, 1'b0);
    endtask

    task automatic testLru();
        fetch("testLru", 25'h0000AAA, 32'h0000_0020, 1'b1);
        fetch("testLru", 25'h0000BBB, 32'h0000_0024, 1'b1);
        fetch("testLru", 25'h0000AAA, 32'h0000_0028, 1'b0);
        // C evicts B, the least recent way
        fetch("testLru", 25'h0000CCC, 32'h0000_002C, 1'b1);
        fetch("testLru", 25'h0000AAA, 32'h0000_0024, 1'b0);
        fetch("testLru", 25'h0000BBB, 32'h0000_0020, 1'b1);
    endtask

    task automatic testInvalidate();
        fetch("testInvalidate", 25'h1234567, 32'h0000_0010, 1'b0);
        @(negedge clk);
        paReady    = 1'b0;
        invalidate = 1'b1;
        @(negedge clk);
        invalidate = 1'b0;
        fetch("testInvalidate", 25'h1234567, 32'h0000_0010, 1'b1);
        fetch("testInvalidate", 25'h1234567, 32'h0000_0014, 1'b0);
    endtask

    task automatic testDisabled();
        @(negedge clk);
        enable = 1'b0;
        fetchUncached("testDisabled", 25'h0155555, 32'h0000_0038);
        fetchUncached("testDisabled", 25'h0155555, 32'h0000_0038);
        @(negedge clk);
        enable = 1'b1;
        fetch("testDisabled", 25'h0155555, 32'h0000_0038, 1'b1);
        fetch("testDisabled", 25'h0155555, 32'h0000_0030, 1'b0);
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        rstN       = 1'b0;
        enable     = 1'b1;
        invalidate = 1'b0;
        paReady    = 1'b0;
        addr       = '0;
        physTag    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        testReset();
        testColdMiss();
        testHit();
        testLru();
        testInvalidate();
        testDisabled();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
icachePkg.sv
icacheArray.sv
icacheHitCompare.sv
icacheController.sv
icache.sv
icacheTbMem.sv
icacheTb.sv

//--- run.sh
#!/bin/sh
# Build and run the cache testbench, status follows the printed verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module icacheTb -f build.f &&
simOut=$(./obj_dir/VicacheTb) &&
echo "$simOut" &&
echo "$simOut" | grep -q "^Verification passed$" ||
{ echo "Simulation did not pass"; exit 1; }
